/* hdl/bt_air_pkg.sv */
`default_nettype none

package bt_air_pkg;

  // access code sync word
  localparam int SYNC_LEN   = 64;
  localparam int SYNC_CNT_W = 7;        // holds 0..64 agreeing bits

  // packet header, after FEC 1/3 majority vote
  localparam int HDR_LEN      = 18;
  localparam int HDR_INFO_LEN = 10;     // lt_addr .. seqn, covered by the HEC
  localparam int HDR_CNT_W    = 5;      // counts 0..18 header bits

  // data whitening, g(D) = D^7 + D^4 + 1
  localparam int WHT_LEN = 7;
  localparam int WHT_TAP = 4;           // stage that takes the feedback xor

  // header error check, g(D) = D^8 + D^7 + D^5 + D^2 + D + 1
  // the D^8 term is the feedback itself; the remaining terms are the taps
  localparam int               HEC_LEN  = 8;
  localparam logic [HEC_LEN-1:0] HEC_POLY = 8'hA7;

  // saturating count of bad headers kept for firmware
  localparam int HEC_ERR_W = 8;

endpackage

`default_nettype wire

/* hdl/bt_hdr_pkg.sv */
`default_nettype none

package bt_hdr_pkg;

  import bt_air_pkg::*;

  // header fields, first bit on air sits at bit 0
  typedef struct packed {
    logic [HEC_LEN-1:0] hec;           // first hec bit on air at hec[0]
    logic               seqn;
    logic               arqn;
    logic               flow;
    logic [3:0]         ptype;
    logic [2:0]         lt_addr;
  } hdr_fields_t;

  // raw view is filled by the bit shifter, field view decodes the same word
  typedef union packed {
    hdr_fields_t        fields;
    logic [HDR_LEN-1:0] raw;
  } hdr_word_u;

  // basic-rate packet type codes
  typedef enum logic [3:0] {
    PT_NULL = 4'h0,
    PT_POLL = 4'h1,
    PT_FHS  = 4'h2,
    PT_DM1  = 4'h3,
    PT_DH1  = 4'h4
  } ptype_e;

endpackage

`default_nettype wire

/* hdl/bt_bitstream_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bt_bitstream_if;

  logic bit_val;      // current bit, or a status bit on the header link
  logic bit_en;       // one-cycle qualifier for bit_val
  logic pkt_start;    // sync word ended on the previous strobe
  logic pkt_abort;    // header in progress was dropped

  modport src (
    output bit_val,
    output bit_en,
    output pkt_start,
    output pkt_abort
  );

  modport dst (
    input bit_val,
    input bit_en,
    input pkt_start,
    input pkt_abort
  );

endinterface

`default_nettype wire

/* hdl/sync_correlator.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_correlator
  import bt_air_pkg::*;
(
  input  logic                  m_clk_6M,
  input  logic                  rst_n,
  input  logic                  rxbit,
  input  logic                  rxbit_en,
  input  logic [SYNC_LEN-1:0]   syncword,
  input  logic [SYNC_CNT_W-1:0] correthreshold,
  output logic                  sync_hit,
  bt_bitstream_if.src           bs
);

  logic [SYNC_LEN-2:0]   window;      // last 63 bits, newest at the top
  logic [SYNC_LEN-1:0]   win_next;    // window including the bit now arriving
  logic [SYNC_LEN-1:0]   agree;
  logic [SYNC_CNT_W-1:0] agree_cnt;
  logic                  hit_d;
  logic                  hit_q;
  logic                  abort_q;
  logic [HDR_CNT_W-1:0]  hdr_left;    // header bits still expected after a hit

  // sync word goes out LSB first, so the oldest bit ends up at bit 0
  assign win_next = {rxbit, window};
  assign agree    = ~(win_next ^ syncword);

  // population count of agreeing positions
  always_comb begin
    agree_cnt = '0;
    for (int i = 0; i < SYNC_LEN; i++) begin
      agree_cnt = agree_cnt + SYNC_CNT_W'(agree[i]);
    end
  end

  assign hit_d = rxbit_en & (agree_cnt >= correthreshold);

  always_ff @(posedge m_clk_6M) begin
    if (!rst_n) begin
      window     <= '0;
      hit_q      <= 1'b0;
      abort_q    <= 1'b0;
      hdr_left   <= '0;
      bs.bit_val <= 1'b0;
      bs.bit_en  <= 1'b0;
    end else begin
      hit_q      <= hit_d;
      abort_q    <= hit_d & (hdr_left != '0);   // re-hit inside a header
      bs.bit_val <= rxbit;                      // stream forwarded, one cycle late
      bs.bit_en  <= rxbit_en;
      if (rxbit_en) begin
        window <= win_next[SYNC_LEN-1:1];
      end
      if (hit_d) begin
        hdr_left <= HDR_CNT_W'(HDR_LEN);
      end else if (rxbit_en && hdr_left != '0) begin
        hdr_left <= hdr_left - 1'b1;
      end
    end
  end

  // hit and framing pulse leave together, in the cycle after the last sync strobe
  assign sync_hit     = hit_q;
  assign bs.pkt_start = hit_q;
  assign bs.pkt_abort = abort_q;

endmodule

`default_nettype wire

/* hdl/header_dewhiten_hec.sv */
`timescale 1ns/1ps
`default_nettype none

module header_dewhiten_hec
  import bt_air_pkg::*;
  import bt_hdr_pkg::*;
(
  input  logic               m_clk_6M,
  input  logic               rst_n,
  input  logic               rxwhitening,
  input  logic [6:1]         clk_bits,
  input  logic [HEC_LEN-1:0] uap,
  bt_bitstream_if.dst        bs,
  bt_bitstream_if.src        hs,
  output hdr_word_u          hdr_word
);

  logic                 busy;        // collecting header bits
  logic [HDR_CNT_W-1:0] bit_cnt;
  logic [WHT_LEN-1:0]   wht;         // whitening lfsr, output at the top stage
  logic [HEC_LEN-1:0]   hec_reg;
  logic [HDR_LEN-2:0]   raw_q;       // bits already received, oldest at bit 0
  logic                 bit_d;       // de-whitened bit
  logic                 take_bit;
  logic                 last_bit;

  // one step of D^7 + D^4 + 1, output fed back to stage 0 and xored at the tap
  function automatic logic [WHT_LEN-1:0] wht_step(input logic [WHT_LEN-1:0] r);
    logic [WHT_LEN-1:0] n;
    n          = {r[WHT_LEN-2:0], r[WHT_LEN-1]};
    n[WHT_TAP] = n[WHT_TAP] ^ r[WHT_LEN-1];
    return n;
  endfunction

  // one step of the hec generator
  function automatic logic [HEC_LEN-1:0] hec_step(input logic [HEC_LEN-1:0] r,
                                                  input logic               d);
    logic fb;
    fb = d ^ r[HEC_LEN-1];
    return {r[HEC_LEN-2:0], 1'b0} ^ ({HEC_LEN{fb}} & HEC_POLY);
  endfunction

  assign bit_d = bs.bit_val ^ (rxwhitening & wht[WHT_LEN-1]);

  // the strobe that comes with pkt_start is still the last sync bit
  assign take_bit = busy & bs.bit_en & ~bs.pkt_start;
  assign last_bit = take_bit & (bit_cnt == HDR_CNT_W'(HDR_LEN - 1));

  // word as it stands after the current bit, valid while last_bit is high
  always_comb begin
    hdr_word.raw = {bit_d, raw_q};
  end

  assign hs.bit_en    = last_bit;                             // done strobe
  assign hs.bit_val   = (hdr_word.fields.hec == hec_reg);     // hec_ok
  assign hs.pkt_start = 1'b0;
  assign hs.pkt_abort = bs.pkt_abort & busy;                  // header dropped

  always_ff @(posedge m_clk_6M) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
    end else if (bs.pkt_start) begin
      busy    <= 1'b1;                  // a re-hit restarts collection here too
      bit_cnt <= '0;
    end else if (take_bit) begin
      bit_cnt <= bit_cnt + 1'b1;
      if (last_bit) begin
        busy <= 1'b0;
      end
    end
  end

  // shifters are seeded on every pkt_start
  always_ff @(posedge m_clk_6M) begin
    if (bs.pkt_start) begin
      wht     <= {1'b1, clk_bits};     // stage 6 set, clk1..clk6 below
      hec_reg <= uap;
    end else if (take_bit) begin
      raw_q <= hdr_word.raw[HDR_LEN-1:1];
      wht   <= wht_step(wht);
      if (bit_cnt < HDR_CNT_W'(HDR_INFO_LEN)) begin
        hec_reg <= hec_step(hec_reg, bit_d);   // info bits only
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/header_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module header_capture
  import bt_air_pkg::*;
  import bt_hdr_pkg::*;
(
  input  logic                 m_clk_6M,
  input  logic                 rst_n,
  bt_bitstream_if.dst          hs,
  input  hdr_word_u            hdr_word,
  output logic                 hdr_valid,
  output logic [2:0]           lt_addr,
  output logic [3:0]           ptype,
  output logic                 flow,
  output logic                 arqn,
  output logic                 seqn,
  output logic                 hec_ok,
  output logic [HEC_ERR_W-1:0] hec_err_cnt
);

  hdr_fields_t fields_q;
  logic        bad_hdr;

  // failed check, or a header lost to a re-hit
  assign bad_hdr = (hs.bit_en & ~hs.bit_val) | hs.pkt_abort;

  always_ff @(posedge m_clk_6M) begin
    if (!rst_n) begin
      hdr_valid   <= 1'b0;
      fields_q    <= '0;
      hec_ok      <= 1'b0;
      hec_err_cnt <= '0;
    end else begin
      hdr_valid <= hs.bit_en;
      if (hs.bit_en) begin
        fields_q <= hdr_word.fields;   // held until the next header
        hec_ok   <= hs.bit_val;
      end
      if (bad_hdr && hec_err_cnt != '1) begin
        hec_err_cnt <= hec_err_cnt + 1'b1;   // sticks at all ones
      end
    end
  end

  assign lt_addr = fields_q.lt_addr;
  assign ptype   = fields_q.ptype;
  assign flow    = fields_q.flow;
  assign arqn    = fields_q.arqn;
  assign seqn    = fields_q.seqn;

endmodule

`default_nettype wire

/* hdl/bt_rx_front.sv */
`timescale 1ns/1ps
`default_nettype none

module bt_rx_front
  import bt_air_pkg::*;
  import bt_hdr_pkg::*;
(
  input  logic                  m_clk_6M,
  input  logic                  rst_n,
  input  logic                  rxbit,
  input  logic                  rxbit_en,
  input  logic                  rxwhitening,
  input  logic [SYNC_LEN-1:0]   syncword,
  input  logic [SYNC_CNT_W-1:0] correthreshold,
  input  logic [6:1]            clk_bits,
  input  logic [HEC_LEN-1:0]    uap,
  output logic                  sync_hit,
  output logic                  hdr_valid,
  output logic [2:0]            lt_addr,
  output logic [3:0]            ptype,
  output logic                  flow,
  output logic                  arqn,
  output logic                  seqn,
  output logic                  hec_ok,
  output logic [HEC_ERR_W-1:0]  hec_err_cnt
);

  bt_bitstream_if bit_link ();   // correlator to header decoder
  bt_bitstream_if hdr_link ();   // header decoder to capture

  hdr_word_u hdr_word;

  sync_correlator u_sync_correlator (
    .m_clk_6M       (m_clk_6M),
    .rst_n          (rst_n),
    .rxbit          (rxbit),
    .rxbit_en       (rxbit_en),
    .syncword       (syncword),
    .correthreshold (correthreshold),
    .sync_hit       (sync_hit),
    .bs             (bit_link.src)
  );

  header_dewhiten_hec u_header_dewhiten_hec (
    .m_clk_6M    (m_clk_6M),
    .rst_n       (rst_n),
    .rxwhitening (rxwhitening),
    .clk_bits    (clk_bits),
    .uap         (uap),
    .bs          (bit_link.dst),
    .hs          (hdr_link.src),
    .hdr_word    (hdr_word)
  );

  header_capture u_header_capture (
    .m_clk_6M    (m_clk_6M),
    .rst_n       (rst_n),
    .hs          (hdr_link.dst),
    .hdr_word    (hdr_word),
    .hdr_valid   (hdr_valid),
    .lt_addr     (lt_addr),
    .ptype       (ptype),
    .flow        (flow),
    .arqn        (arqn),
    .seqn        (seqn),
    .hec_ok      (hec_ok),
    .hec_err_cnt (hec_err_cnt)
  );

endmodule

`default_nettype wire

/* verification/tb_bt_rx_front.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bt_rx_front
  import bt_air_pkg::*;
  import bt_hdr_pkg::*;
();

  localparam int SEED      = 82567;
  localparam int NUM_ROWS  = 12;
  localparam int SYNC_WAIT = 16;   // cycles allowed for sync_hit after the last sync bit
  localparam int HDR_WAIT  = 16;   // cycles allowed for hdr_valid after the last header bit

  typedef struct packed {
    logic [SYNC_LEN-1:0]   sync;
    logic [3:0]            flips;      // sync bits inverted on air
    logic [SYNC_CNT_W-1:0] thr;
    logic [HEC_LEN-1:0]    uap;
    logic [6:1]            clk;
    logic                  tx_wht;
    logic                  rx_wht;
    logic                  rand_gap;
    logic                  bad_hec;
    logic                  bad_uap;    // receiver programmed with another uap
    hdr_fields_t           hdr;
  } row_t;

  logic                  m_clk_6M = 1'b0;
  logic                  rst_n;
  logic                  rxbit;
  logic                  rxbit_en;
  logic                  rxwhitening;
  logic [SYNC_LEN-1:0]   syncword;
  logic [SYNC_CNT_W-1:0] correthreshold;
  logic [6:1]            clk_bits;
  logic [HEC_LEN-1:0]    uap;
  logic                  sync_hit;
  logic                  hdr_valid;
  logic [2:0]            lt_addr;
  logic [3:0]            ptype;
  logic                  flow;
  logic                  arqn;
  logic                  seqn;
  logic                  hec_ok;
  logic [HEC_ERR_W-1:0]  hec_err_cnt;

  row_t                 rows [NUM_ROWS];
  int                   mismatch_cnt;
  int                   event_cnt;      // missing or unexpected pulses
  int                   cur_row;
  logic [HEC_ERR_W-1:0] exp_err_cnt;

  bt_rx_front u_dut (
    .m_clk_6M       (m_clk_6M),
    .rst_n          (rst_n),
    .rxbit          (rxbit),
    .rxbit_en       (rxbit_en),
    .rxwhitening    (rxwhitening),
    .syncword       (syncword),
    .correthreshold (correthreshold),
    .clk_bits       (clk_bits),
    .uap            (uap),
    .sync_hit       (sync_hit),
    .hdr_valid      (hdr_valid),
    .lt_addr        (lt_addr),
    .ptype          (ptype),
    .flow           (flow),
    .arqn           (arqn),
    .seqn           (seqn),
    .hec_ok         (hec_ok),
    .hec_err_cnt    (hec_err_cnt)
  );

  always #4 m_clk_6M = ~m_clk_6M;   // 125 MHz stand-in for the 6 MHz clock

  // hec of the info bits with g = x^8+x^7+x^5+x^2+x+1 and the first bit on air at bit 0
  function automatic logic [HEC_LEN-1:0] hec_calc(input logic [HEC_LEN-1:0] seed,
                                                  input logic [HDR_INFO_LEN-1:0] info);
    logic [HEC_LEN-1:0] r;
    logic               fb;
    r = seed;
    for (int i = 0; i < HDR_INFO_LEN; i++) begin
      fb = info[i] ^ r[HEC_LEN-1];
      r  = {r[HEC_LEN-2:0], 1'b0} ^ (fb ? 8'hA7 : 8'h00);   // taps x^7 x^5 x^2 x 1
    end
    return r;
  endfunction

  // 18-bit whitening mask from x^7+x^4+1 seeded with 1 and clk6..clk1
  function automatic logic [HDR_LEN-1:0] whiten_mask(input logic [6:1] clk);
    logic [WHT_LEN-1:0] r;
    logic [HDR_LEN-1:0] m;
    logic               fb;
    r = {1'b1, clk};
    for (int i = 0; i < HDR_LEN; i++) begin
      fb   = r[WHT_LEN-1];
      m[i] = fb;
      r    = {r[WHT_LEN-2:0], 1'b0} ^ (fb ? 7'h11 : 7'h00);
    end
    return m;
  endfunction

  function automatic row_t make_row(input logic [SYNC_LEN-1:0] sync, input int flips,
                                    input int thr, input logic [HEC_LEN-1:0] uap_v,
                                    input logic [6:1] clk, input logic [4:0] flags,
                                    input logic [2:0] lt, input ptype_e pt,
                                    input logic [2:0] fas);
    row_t r;
    r.sync  = sync;
    r.flips = 4'(flips);
    r.thr   = SYNC_CNT_W'(thr);
    r.uap   = uap_v;
    r.clk   = clk;
    {r.tx_wht, r.rx_wht, r.rand_gap, r.bad_hec, r.bad_uap} = flags;
    r.hdr.lt_addr = lt;
    r.hdr.ptype   = pt;
    {r.hdr.flow, r.hdr.arqn, r.hdr.seqn} = fas;
    r.hdr.hec     = '0;   // filled in from the model when sent
    return r;
  endfunction

  // sync, flips, threshold, uap, clk_bits, {tx_wht, rx_wht, rand_gap, bad_hec, bad_uap},
  // lt_addr, ptype, {flow, arqn, seqn}
  task automatic load_table();
    rows[0]  = make_row(64'h9e8b_3f2c_1a6d_47b5, 0, 64, 8'h47, 6'h00, 5'b00000,
                        3'd3, PT_DM1, 3'b101);
    rows[1]  = make_row(64'h4c2e_91d7_b06a_35f8, 4, 60, 8'h47, 6'h00, 5'b00000,
                        3'd5, PT_POLL, 3'b010);
    rows[2]  = make_row(64'h4c2e_91d7_b06a_35f8, 2, 60, 8'h9c, 6'h00, 5'b00100,
                        3'd1, PT_DH1, 3'b111);
    rows[3]  = make_row(64'h4c2e_91d7_b06a_35f8, 5, 60, 8'h9c, 6'h00, 5'b00000,
                        3'd2, PT_NULL, 3'b000);
    rows[4]  = make_row(64'hd36f_0a85_7c19_e2b4, 0, 64, 8'h6e, 6'h15, 5'b11000,
                        3'd7, PT_FHS, 3'b100);
    rows[5]  = make_row(64'hd36f_0a85_7c19_e2b4, 1, 62, 8'h6e, 6'h3f, 5'b11100,
                        3'd4, PT_DH1, 3'b011);
    rows[6]  = make_row(64'h9e8b_3f2c_1a6d_47b5, 0, 64, 8'h21, 6'h01, 5'b11000,
                        3'd0, PT_NULL, 3'b110);
    rows[7]  = make_row(64'hd36f_0a85_7c19_e2b4, 0, 64, 8'h6e, 6'h2a, 5'b10000,
                        3'd6, PT_DM1, 3'b001);
    rows[8]  = make_row(64'h9e8b_3f2c_1a6d_47b5, 0, 64, 8'h47, 6'h00, 5'b00010,
                        3'd3, PT_POLL, 3'b100);
    rows[9]  = make_row(64'h4c2e_91d7_b06a_35f8, 3, 61, 8'hb2, 6'h0c, 5'b00001,
                        3'd2, PT_FHS, 3'b010);
    rows[10] = make_row(64'hd36f_0a85_7c19_e2b4, 0, 64, 8'h5d, 6'h33, 5'b11010,
                        3'd1, PT_DM1, 3'b101);
    rows[11] = make_row(64'h9e8b_3f2c_1a6d_47b5, 0, 64, 8'h47, 6'h2a, 5'b10100,
                        3'd5, PT_DH1, 3'b011);
  endtask

  function automatic int next_gap(input logic rand_gap);
    return rand_gap ? int'($urandom_range(6, 0)) : 5;   // 5 idle cycles = one bit per 6
  endfunction

  // idle cycles first, then the strobe goes high with the bit
  task automatic send_bit(input logic b, input int gap);
    repeat (gap) begin
      @(posedge m_clk_6M);
      rxbit_en <= 1'b0;
    end
    @(posedge m_clk_6M);
    rxbit    <= b;
    rxbit_en <= 1'b1;
  endtask

  // cycles counts rising edges after the last strobe cycle until the pulse shows
  task automatic wait_for_pulse(input bit on_valid, input int limit,
                                output bit seen, output int cycles);
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < limit) begin
      @(negedge m_clk_6M);
      if ((on_valid ? hdr_valid : sync_hit) === 1'b1) begin
        seen = 1'b1;
      end else begin
        @(posedge m_clk_6M);
        rxbit_en <= 1'b0;
        cycles++;
      end
    end
  endtask

  task automatic check_fields(input hdr_fields_t exp);
    ptype_e got_pt;
    got_pt = ptype_e'(ptype);
    if (lt_addr !== exp.lt_addr) begin
      mismatch_cnt++;
      $display("Mismatch lt_addr: expected 0x%0h, got 0x%0h (row %0d)", exp.lt_addr, lt_addr,
               cur_row);
    end
    if (got_pt !== ptype_e'(exp.ptype)) begin
      mismatch_cnt++;
      $display("Mismatch ptype: expected 0x%0h, got 0x%0h (row %0d)", exp.ptype, ptype, cur_row);
    end
    if ({flow, arqn, seqn} !== {exp.flow, exp.arqn, exp.seqn}) begin
      mismatch_cnt++;
      $display("Mismatch flow/arqn/seqn: expected 0x%0h, got 0x%0h (row %0d)",
               {exp.flow, exp.arqn, exp.seqn}, {flow, arqn, seqn}, cur_row);
    end
  endtask

  task automatic check_flag(input logic exp, input logic got, input string name);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected 0x%0h, got 0x%0h (row %0d)", name, exp, got, cur_row);
    end
  endtask

  task automatic check_count(input logic [HEC_ERR_W-1:0] exp, input logic [HEC_ERR_W-1:0] got,
                             input string name);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected 0x%0h, got 0x%0h (row %0d)", name, exp, got, cur_row);
    end
  endtask

  task automatic check_latency(input int exp, input int got, input string name);
    if (got != exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected 0x%0h, got 0x%0h (row %0d)", name, exp, got, cur_row);
    end
  endtask

  task automatic run_row(input row_t r);
    hdr_word_u           tx_w;
    hdr_word_u           rx_w;
    logic [HDR_LEN-1:0]  wmask;
    logic [HDR_LEN-1:0]  air;
    logic [SYNC_LEN-1:0] flip;
    logic [HEC_LEN-1:0]  rx_uap;
    logic                exp_ok;
    logic                hit_exp;
    bit                  seen;
    int                  cycles;
    int                  idx;
    int                  n;
    tx_w.fields     = r.hdr;
    tx_w.fields.hec = hec_calc(r.uap, tx_w.raw[HDR_INFO_LEN-1:0]) ^ (r.bad_hec ? 8'h24 : 8'h00);
    wmask   = whiten_mask(r.clk);
    air     = tx_w.raw ^ (r.tx_wht ? wmask : '0);
    rx_w.raw = air ^ (r.rx_wht ? wmask : '0);   // what the receiver should rebuild
    rx_uap  = r.bad_uap ? (r.uap ^ 8'h5a) : r.uap;
    exp_ok  = (hec_calc(rx_uap, rx_w.raw[HDR_INFO_LEN-1:0]) == rx_w.fields.hec);
    hit_exp = (SYNC_LEN - int'(r.flips)) >= int'(r.thr);
    flip = '0;
    n    = 0;
    while (n < int'(r.flips)) begin   // distinct random positions
      idx = int'($urandom_range(SYNC_LEN - 1, 0));
      if (!flip[idx]) begin
        flip[idx] = 1'b1;
        n++;
      end
    end
    @(posedge m_clk_6M);
    rxbit_en       <= 1'b0;
    syncword       <= r.sync;
    correthreshold <= r.thr;
    uap            <= rx_uap;
    clk_bits       <= r.clk;
    rxwhitening    <= r.rx_wht;
    n = int'($urandom_range(12, 4));
    repeat (n) send_bit(1'($urandom_range(1, 0)), next_gap(r.rand_gap));   // pad bits
    for (int i = 0; i < SYNC_LEN; i++) begin
      send_bit(r.sync[i] ^ flip[i], next_gap(r.rand_gap));   // lsb first
    end
    wait_for_pulse(1'b0, SYNC_WAIT, seen, cycles);
    if (hit_exp && !seen) begin
      event_cnt++;
      $display("row %0d: no sync_hit within %0d cycles after the sync word", cur_row, SYNC_WAIT);
    end else if (!hit_exp && seen) begin
      event_cnt++;
      $display("row %0d: sync_hit appeared with %0d flipped bits and threshold %0d",
               cur_row, r.flips, r.thr);
    end else if (seen) begin
      check_latency(1, cycles, "sync_hit latency");
    end
    for (int i = 0; i < HDR_LEN; i++) begin
      send_bit(air[i], next_gap(r.rand_gap));
    end
    wait_for_pulse(1'b1, HDR_WAIT, seen, cycles);
    if (hit_exp && !seen) begin
      event_cnt++;
      $display("row %0d: no hdr_valid within %0d cycles after the last header bit",
               cur_row, HDR_WAIT);
    end else if (!hit_exp && seen) begin
      event_cnt++;
      $display("row %0d: hdr_valid appeared although the sync word was not found", cur_row);
    end else if (seen) begin
      check_latency(2, cycles, "hdr_valid latency");
      check_fields(rx_w.fields);
      check_flag(exp_ok, hec_ok, "hec_ok");
    end
    if (hit_exp && !exp_ok) begin
      exp_err_cnt = exp_err_cnt + 1'b1;
    end
    check_count(exp_err_cnt, hec_err_cnt, "hec_err_cnt");
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n          = 1'b0;
    rxbit          = 1'b0;
    rxbit_en       = 1'b0;
    rxwhitening    = 1'b0;
    syncword       = '0;
    correthreshold = '0;
    clk_bits       = '0;
    uap            = '0;
    mismatch_cnt   = 0;
    event_cnt      = 0;
    cur_row        = -1;
    exp_err_cnt    = '0;
    load_table();
    repeat (2) @(posedge m_clk_6M);
    rst_n <= 1'b1;
    repeat (3) @(negedge m_clk_6M);
    check_flag(1'b0, sync_hit, "sync_hit");   // idle state straight out of reset
    check_flag(1'b0, hdr_valid, "hdr_valid");
    check_flag(1'b0, hec_ok, "hec_ok");
    check_fields('0);
    check_count('0, hec_err_cnt, "hec_err_cnt");
    for (int i = 0; i < NUM_ROWS; i++) begin
      cur_row = i;
      run_row(rows[i]);
    end
    repeat (4) @(posedge m_clk_6M);
    $display("checks done: %0d mismatches, %0d missing or unexpected pulses",
             mismatch_cnt, event_cnt);
    if (mismatch_cnt == 0 && event_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bt_rx_front.f */
hdl/bt_air_pkg.sv
hdl/bt_hdr_pkg.sv
hdl/bt_bitstream_if.sv
hdl/sync_correlator.sv
hdl/header_dewhiten_hec.sv
hdl/header_capture.sv
hdl/bt_rx_front.sv
verification/tb_bt_rx_front.sv
